//--- Makefile
VERILATOR ?= verilator
TOP       := tb_vdec_top
FILELIST  := sources.f
FLAGS     := --binary --timing --assert --timescale 1ns/1ns
OBJ_DIR   := obj_dir
PASS_TEXT := ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation reads testbench/vdec_vectors.txt relative to this directory
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- design/vdec_cmd_accept.sv
// command req/ack handshake, command latch, effective width and element limit decode
`timescale 1ns/1ns

module vdec_cmd_accept
  import vdec_pkg::*;
#(
  parameter int VLENB = 16
) (
  input  logic      CLK,
  input  logic      nRST,
  input  logic      flush,
  input  logic      cmd_req,
  input  vdec_cmd_t cmd,
  input  logic      done,
  output logic      cmd_ack,
  output logic      start,
  output vdec_cmd_t cur_cmd,
  output sew_t      eew,
  output offset_t   start_offset,
  output offset_t   limit
);

  logic    busy;
  logic    accept;
  offset_t capacity;

  // take a new command only when nothing is in flight and the last ack has dropped
  assign accept = cmd_req & ~cmd_ack & ~busy & ~flush;

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      cmd_ack <= 1'b0;
      busy    <= 1'b0;
      start   <= 1'b0;
    end else if (flush) begin
      // abort, ack still waits for req to drop
      busy    <= 1'b0;
      start   <= 1'b0;
      cmd_ack <= cmd_ack & cmd_req;
    end else begin
      start <= accept;
      if (accept) begin
        cmd_ack <= 1'b1;
        busy    <= 1'b1;
      end else if (cmd_ack & ~cmd_req) begin
        cmd_ack <= 1'b0;
      end
      if (done) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      cur_cmd <= cmd;
    end
  end

  // widened or narrowed destination width
  always_comb begin
    eew = cur_cmd.sew;
    if (cur_cmd.vd_widen) begin
      eew = (cur_cmd.sew == SEW8) ? SEW16 : SEW32;
    end else if (cur_cmd.vd_narrow) begin
      eew = (cur_cmd.sew == SEW32) ? SEW16 : SEW8;
    end
  end

  // elements that fit one register at the source SEW
  assign capacity     = offset_t'(VLENB >> cur_cmd.sew);
  assign limit        = (cur_cmd.vl < capacity) ? cur_cmd.vl : capacity;
  assign start_offset = cur_cmd.vstart;

endmodule

//--- design/vdec_element_counter.sv
// two-lane element offset counter with last, done and stall handling
`timescale 1ns/1ns

module vdec_element_counter
  import vdec_pkg::*;
(
  input  logic    CLK,
  input  logic    nRST,
  input  logic    flush,
  input  logic    stall,
  input  logic    start,
  input  offset_t start_offset,
  input  offset_t limit,
  output offset_t offset,
  output logic    beat_go,
  output logic    last,
  output logic    done
);

  // one extra bit so offset+2 cannot wrap past the limit
  localparam int CW = OFFSET_W + 1;

  logic          active;
  logic [CW-1:0] next_pair;

  assign next_pair = {1'b0, offset} + CW'(2);

  // a pair is presented whenever a command is being stepped
  assign beat_go = active;

  // also covers vstart at or above the limit, which gives a single beat
  assign last = active & (next_pair >= {1'b0, limit});

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      active <= 1'b0;
      offset <= '0;
      done   <= 1'b0;
    end else if (flush) begin
      active <= 1'b0;
      done   <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        active <= 1'b1;
        offset <= start_offset;
      end else if (active & ~stall) begin
        if (last) begin
          // final pair leaves this cycle, tell the handshake next cycle
          active <= 1'b0;
          done   <= 1'b1;
        end else begin
          offset <= next_pair[OFFSET_W-1:0];
        end
      end
    end
  end

endmodule

//--- design/vdec_operand_stage.sv
// vs2 and vd offset selection, masked write enables and the registered beat output
`timescale 1ns/1ns

module vdec_operand_stage
  import vdec_pkg::*;
(
  input  logic       CLK,
  input  logic       nRST,
  input  logic       flush,
  input  logic       stall,
  input  vdec_cmd_t  cur_cmd,
  input  sew_t       eew,
  input  offset_t    offset,
  input  offset_t    limit,
  input  logic       beat_go,
  input  logic       last,
  output logic       beat_valid,
  output vdec_beat_t beat
);

  localparam int CW     = OFFSET_W + 1;
  localparam int MIDX_W = $clog2(MASK_W);

  typedef struct packed {
    offset_t o0;
    offset_t o1;
  } lane_pair_t;

  offset_t    rs1_off;
  offset_t    uimm_off;
  offset_t    offset1;
  vs2_src_t   vd_as_src;
  lane_pair_t vs2_pair;
  lane_pair_t vd_pair;
  logic       in_range0;
  logic       in_range1;
  logic       active0;
  logic       active1;
  vdec_beat_t next_beat;

  // offsets for both lanes, everything wraps at OFFSET_W bits
  function automatic lane_pair_t pick_offsets(
    input vs2_src_t src,
    input offset_t  off,
    input offset_t  rs1,
    input offset_t  uimm
  );
    lane_pair_t p;
    case (src)
      VS2_SRC_NORMAL: begin
        p.o0 = off;
        p.o1 = off + offset_t'(1);
      end
      VS2_SRC_IDX_PLUS_RS1: begin
        p.o0 = off + rs1;
        p.o1 = off + rs1 + offset_t'(1);
      end
      VS2_SRC_IDX_PLUS_UIMM: begin
        p.o0 = off + uimm;
        p.o1 = off + uimm + offset_t'(1);
      end
      VS2_SRC_IDX_PLUS_1: begin
        p.o0 = off + offset_t'(1);
        p.o1 = off + offset_t'(2);
      end
      VS2_SRC_IDX_MINUS_1: begin
        p.o0 = off - offset_t'(1);
        p.o1 = off;
      end
      VS2_SRC_RS1: begin
        p.o0 = rs1;
        p.o1 = rs1;
      end
      VS2_SRC_UIMM: begin
        p.o0 = uimm;
        p.o1 = uimm;
      end
      default: begin
        p.o0 = '0;
        p.o1 = '0;
      end
    endcase
    return p;
  endfunction

  assign rs1_off  = cur_cmd.xs1[OFFSET_W-1:0];
  assign uimm_off = {{(OFFSET_W-5){1'b0}}, cur_cmd.imm5};
  assign offset1  = offset + offset_t'(1);

  // vd sources are a subset of the vs2 ones with the same lane rules
  always_comb begin
    case (cur_cmd.vd_src)
      VD_SRC_NORMAL:        vd_as_src = VS2_SRC_NORMAL;
      VD_SRC_IDX_PLUS_RS1:  vd_as_src = VS2_SRC_IDX_PLUS_RS1;
      VD_SRC_IDX_PLUS_UIMM: vd_as_src = VS2_SRC_IDX_PLUS_UIMM;
      VD_SRC_IDX_PLUS_1:    vd_as_src = VS2_SRC_IDX_PLUS_1;
      default:              vd_as_src = VS2_SRC_ZERO;
    endcase
  end

  assign vs2_pair = pick_offsets(cur_cmd.vs2_src, offset, rs1_off, uimm_off);
  assign vd_pair  = pick_offsets(vd_as_src, offset, rs1_off, uimm_off);

  // element index against the clamped limit, not the vd offset
  assign in_range0 = {1'b0, offset} < {1'b0, limit};
  assign in_range1 = ({1'b0, offset} + CW'(1)) < {1'b0, limit};

  // v0 bit per element, ignored when unmasked
  assign active0 = cur_cmd.vm | cur_cmd.mask[offset[MIDX_W-1:0]];
  assign active1 = cur_cmd.vm | cur_cmd.mask[offset1[MIDX_W-1:0]];

  always_comb begin
    next_beat.woffset0    = vd_pair.o0;
    next_beat.woffset1    = vd_pair.o1;
    next_beat.vs2_offset0 = vs2_pair.o0;
    next_beat.vs2_offset1 = vs2_pair.o1;
    next_beat.wen0        = in_range0 & active0;
    next_beat.wen1        = in_range1 & active1;
    next_beat.eew         = eew;
    next_beat.last        = last;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      beat_valid <= 1'b0;
      beat       <= '0;
    end else if (flush) begin
      beat_valid <= 1'b0;
    end else if (~stall) begin
      beat_valid <= beat_go;
      if (beat_go) begin
        beat <= next_beat;
      end
    end
  end

endmodule

//--- design/vdec_pkg.sv
// shared widths, element width and offset source encodings, command and beat structs
package vdec_pkg;

  // element offset width, enough for VLENB up to 32 at SEW8 plus headroom
  localparam int OFFSET_W = 8;
  localparam int XLEN     = 32;
  localparam int MASK_W   = 32;

  typedef logic [OFFSET_W-1:0] offset_t;

  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  // where the vs2 lane offsets come from
  typedef enum logic [2:0] {
    VS2_SRC_NORMAL        = 3'd0,
    VS2_SRC_ZERO          = 3'd1,
    VS2_SRC_IDX_PLUS_RS1  = 3'd2,
    VS2_SRC_IDX_PLUS_UIMM = 3'd3,
    VS2_SRC_IDX_PLUS_1    = 3'd4,
    VS2_SRC_IDX_MINUS_1   = 3'd5,
    VS2_SRC_RS1           = 3'd6,
    VS2_SRC_UIMM          = 3'd7
  } vs2_src_t;

  // where the destination lane offsets come from
  typedef enum logic [2:0] {
    VD_SRC_NORMAL        = 3'd0,
    VD_SRC_ZERO          = 3'd1,
    VD_SRC_IDX_PLUS_RS1  = 3'd2,
    VD_SRC_IDX_PLUS_UIMM = 3'd3,
    VD_SRC_IDX_PLUS_1    = 3'd4
  } vd_src_t;

  // decoded vector operation as handed to the sequencer
  typedef struct packed {
    sew_t              sew;
    logic              vd_widen;
    logic              vd_narrow;
    logic              vm;
    vs2_src_t          vs2_src;
    vd_src_t           vd_src;
    logic [4:0]        imm5;
    logic [XLEN-1:0]   xs1;
    offset_t           vl;
    offset_t           vstart;
    logic [MASK_W-1:0] mask;
  } vdec_cmd_t;

  // one two-lane beat towards execute
  typedef struct packed {
    offset_t woffset0;
    offset_t woffset1;
    offset_t vs2_offset0;
    offset_t vs2_offset1;
    logic    wen0;
    logic    wen1;
    sew_t    eew;
    logic    last;
  } vdec_beat_t;

endpackage

//--- design/vdec_top.sv
// vector element sequencer top, handshake, counter and operand stage chained
`timescale 1ns/1ns

module vdec_top
  import vdec_pkg::*;
#(
  // register length in bytes, at most 32
  parameter int VLENB = 16
) (
  input  logic       CLK,
  input  logic       nRST,
  input  logic       flush,
  input  logic       cmd_req,
  input  vdec_cmd_t  cmd,
  input  logic       beat_stall,
  output logic       cmd_ack,
  output logic       beat_valid,
  output vdec_beat_t beat
);

  logic      start;
  logic      done;
  logic      beat_go;
  logic      last;
  vdec_cmd_t cur_cmd;
  sew_t      eew;
  offset_t   start_offset;
  offset_t   limit;
  offset_t   offset;

  vdec_cmd_accept #(
    .VLENB(VLENB)
  ) u_cmd_accept (
    .CLK         (CLK),
    .nRST        (nRST),
    .flush       (flush),
    .cmd_req     (cmd_req),
    .cmd         (cmd),
    .done        (done),
    .cmd_ack     (cmd_ack),
    .start       (start),
    .cur_cmd     (cur_cmd),
    .eew         (eew),
    .start_offset(start_offset),
    .limit       (limit)
  );

  vdec_element_counter u_element_counter (
    .CLK         (CLK),
    .nRST        (nRST),
    .flush       (flush),
    .stall       (beat_stall),
    .start       (start),
    .start_offset(start_offset),
    .limit       (limit),
    .offset      (offset),
    .beat_go     (beat_go),
    .last        (last),
    .done        (done)
  );

  vdec_operand_stage u_operand_stage (
    .CLK       (CLK),
    .nRST      (nRST),
    .flush     (flush),
    .stall     (beat_stall),
    .cur_cmd   (cur_cmd),
    .eew       (eew),
    .offset    (offset),
    .limit     (limit),
    .beat_go   (beat_go),
    .last      (last),
    .beat_valid(beat_valid),
    .beat      (beat)
  );

endmodule

//--- sources.f
design/vdec_pkg.sv
design/vdec_cmd_accept.sv
design/vdec_element_counter.sv
design/vdec_operand_stage.sv
design/vdec_top.sv
testbench/tb_clock_gen.sv
testbench/tb_vdec_top.sv

//--- testbench/tb_clock_gen.sv
// testbench clock and power-on reset generator
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 5
) (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  // reset released just after a rising edge
  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1;
    nRST = 1'b1;
  end

endmodule

//--- testbench/tb_vdec_top.sv
// vector element sequencer testbench with vector file reader, beat predictor and checker
`timescale 1ns/1ns

module tb_vdec_top
  import vdec_pkg::*;
();

  localparam int VLENB = 16;

  typedef struct packed {
    vdec_cmd_t  cmd;
    sew_t       eew;
    logic [7:0] beats;
    logic [7:0] flush_after;
  } vec_t;

  logic       CLK;
  logic       nRST;
  logic       flush;
  logic       cmd_req;
  vdec_cmd_t  cmd;
  logic       beat_stall;
  logic       cmd_ack;
  logic       beat_valid;
  vdec_beat_t beat;

  vec_t       vecs[$];
  vdec_beat_t exp_q[$];
  int         count_q[$];
  int         error_count;
  int         check_count;
  int         beats_seen;
  int         cmd_beats;
  int         cycles;
  int         cycle_limit;
  bit         in_flight;
  bit         after_flush;
  bit         prev_req;
  bit         prev_ack;

  tb_clock_gen #(.PERIOD(8), .RESET_CYCLES(5)) clk_gen (.CLK(CLK), .nRST(nRST));

  vdec_top #(
    .VLENB(VLENB)
  ) UUT (
    .CLK       (CLK),
    .nRST      (nRST),
    .flush     (flush),
    .cmd_req   (cmd_req),
    .cmd       (cmd),
    .beat_stall(beat_stall),
    .cmd_ack   (cmd_ack),
    .beat_valid(beat_valid),
    .beat      (beat)
  );

  task automatic report_failure(input string msg);
    error_count++;
    $display("%s at %0t ns", msg, $time);
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    check_count++;
    assert (actual === expected) else begin
      error_count++;
      $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  task automatic finish_run(input bit timed_out);
    $display("checks: %0d, errors: %0d, beats: %0d", check_count, error_count, beats_seen);
    if (!timed_out && error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  task automatic step_cycle();
    @(posedge CLK);
    #1;
  endtask

  // offset of lane 0 or 1 before truncation to OFFSET_W
  function automatic int lane_offset(input vs2_src_t src, input int lane, input int off,
                                     input int xs, input int im);
    case (src)
      VS2_SRC_NORMAL:        return off + lane;
      VS2_SRC_IDX_PLUS_RS1:  return off + xs + lane;
      VS2_SRC_IDX_PLUS_UIMM: return off + im + lane;
      VS2_SRC_IDX_PLUS_1:    return off + 1 + lane;
      VS2_SRC_IDX_MINUS_1:   return off - 1 + lane;
      VS2_SRC_RS1:           return xs;
      VS2_SRC_UIMM:          return im;
      default:               return 0;
    endcase
  endfunction

  // queue every beat of one command
  // vd codes share the vs2 numbering
  task automatic predict_beats(input vdec_cmd_t c, input sew_t e);
    int         cap;
    int         lim;
    int         off;
    int         xs;
    int         im;
    vdec_beat_t b;
    cap = VLENB >> c.sew;
    lim = (int'(c.vl) < cap) ? int'(c.vl) : cap;
    off = int'(c.vstart);
    xs  = int'(c.xs1);
    im  = int'(c.imm5);
    b   = '0;
    while (!b.last) begin
      b.woffset0    = offset_t'(lane_offset(vs2_src_t'(c.vd_src), 0, off, xs, im));
      b.woffset1    = offset_t'(lane_offset(vs2_src_t'(c.vd_src), 1, off, xs, im));
      b.vs2_offset0 = offset_t'(lane_offset(c.vs2_src, 0, off, xs, im));
      b.vs2_offset1 = offset_t'(lane_offset(c.vs2_src, 1, off, xs, im));
      b.wen0        = (off < lim) && (c.vm || c.mask[5'(off)]);
      b.wen1        = (off + 1 < lim) && (c.vm || c.mask[5'(off + 1)]);
      b.eew         = e;
      b.last        = (off + 2 >= lim);
      exp_q.push_back(b);
      off += 2;
    end
  endtask

  task automatic read_vectors();
    int          fd;
    int          n;
    string       line;
    logic [31:0] col [14];
    vec_t        v;
    fd = $fopen("testbench/vdec_vectors.txt", "r");
    assert (fd != 0) else report_failure("cannot open testbench/vdec_vectors.txt");
    if (fd == 0) return;
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.substr(0, 1) == "//") continue;
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h", col[0], col[1],
                  col[2], col[3], col[4], col[5], col[6], col[7], col[8], col[9],
                  col[10], col[11], col[12], col[13]);
      if (n != 14) continue;
      v.cmd.sew       = sew_t'(col[0][1:0]);
      v.cmd.vd_widen  = col[1][0];
      v.cmd.vd_narrow = col[2][0];
      v.cmd.vm        = col[3][0];
      v.cmd.vs2_src   = vs2_src_t'(col[4][2:0]);
      v.cmd.vd_src    = vd_src_t'(col[5][2:0]);
      v.cmd.imm5      = col[6][4:0];
      v.cmd.xs1       = col[7];
      v.cmd.vl        = col[8][7:0];
      v.cmd.vstart    = col[9][7:0];
      v.cmd.mask      = col[10];
      v.eew           = sew_t'(col[11][1:0]);
      v.beats         = col[12][7:0];
      v.flush_after   = col[13][7:0];
      vecs.push_back(v);
    end
    $fclose(fd);
    assert (vecs.size() != 0) else report_failure("no vectors found in the vector file");
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0) step_cycle();
  endtask

  // four-phase handshake and an optional flush after some beats
  task automatic run_vector(input vec_t v);
    int base;
    if (v.flush_after != 8'd0) wait_idle();
    base = beats_seen;
    predict_beats(v.cmd, v.eew);
    count_q.push_back(int'(v.beats));
    cmd     = v.cmd;
    cmd_req = 1'b1;
    while (cmd_ack !== 1'b1) step_cycle();
    cmd_req = 1'b0;
    while (cmd_ack !== 1'b0) step_cycle();
    if (v.flush_after != 8'd0) begin
      while (beats_seen - base < int'(v.flush_after)) step_cycle();
      flush = 1'b1;
      step_cycle();
      flush = 1'b0;
    end
  endtask

  task automatic check_beat();
    vdec_beat_t e;
    assert (exp_q.size() != 0) else report_failure("beat_valid set with no beat expected");
    if (exp_q.size() != 0) begin
      e = exp_q.pop_front();
      compare_value("beat.woffset0", 32'(e.woffset0), 32'(beat.woffset0));
      compare_value("beat.woffset1", 32'(e.woffset1), 32'(beat.woffset1));
      compare_value("beat.vs2_offset0", 32'(e.vs2_offset0), 32'(beat.vs2_offset0));
      compare_value("beat.vs2_offset1", 32'(e.vs2_offset1), 32'(beat.vs2_offset1));
      compare_value("beat.wen0", 32'(e.wen0), 32'(beat.wen0));
      compare_value("beat.wen1", 32'(e.wen1), 32'(beat.wen1));
      compare_value("beat.eew", 32'(e.eew), 32'(beat.eew));
      compare_value("beat.last", 32'(e.last), 32'(beat.last));
      beats_seen++;
      cmd_beats++;
      // the DUT's own last flag closes the command
      if (beat.last) begin
        assert (count_q.size() != 0) else report_failure("last beat with no command pending");
        if (count_q.size() != 0) begin
          compare_value("beat count", 32'(count_q.pop_front()), 32'(cmd_beats));
        end
        cmd_beats = 0;
      end
    end
  endtask

  // outputs are settled at the falling edge
  // a beat is taken when not stalled
  always @(negedge CLK) begin
    if (nRST) begin
      if (flush) begin
        exp_q.delete();
        count_q.delete();
        cmd_beats   = 0;
        in_flight   = 1'b0;
        after_flush = 1'b1;
      end else begin
        if (after_flush) begin
          assert (!beat_valid) else report_failure("beat_valid still set after flush");
          after_flush = 1'b0;
        end
        if (beat_valid && beat.last) in_flight = 1'b0;
        if (beat_valid && !beat_stall) check_beat();
      end
      if (cmd_ack && !prev_ack) begin
        assert (prev_req) else report_failure("cmd_ack rose without cmd_req");
        assert (!in_flight) else report_failure("cmd_ack given before the previous last beat");
        in_flight = 1'b1;
      end
      if (!cmd_ack && prev_ack) begin
        assert (!prev_req) else report_failure("cmd_ack fell while cmd_req was still high");
      end
      prev_req = cmd_req;
      prev_ack = cmd_ack;
    end
  end

  // random back-pressure
  always @(posedge CLK) begin
    #1;
    beat_stall = ($urandom % 4) == 0;
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      report_failure($sformatf("timeout, run still busy after %0d cycles", cycles));
      finish_run(1'b1);
    end
  end

  initial begin
    flush      = 1'b0;
    cmd_req    = 1'b0;
    cmd        = '0;
    beat_stall = 1'b0;
    void'($urandom(22408));
    read_vectors();
    cycle_limit = 40 * vecs.size() + 200;
    wait (nRST === 1'b1);
    step_cycle();
    assert (cmd_ack === 1'b0 && beat_valid === 1'b0 && beat === '0)
      else report_failure("outputs not cleared by reset");
    foreach (vecs[i]) begin
      run_vector(vecs[i]);
    end
    wait_idle();
    repeat (4) step_cycle();
    assert (count_q.size() == 0) else report_failure("a command never showed its last beat");
    finish_run(1'b0);
  end

endmodule

//--- testbench/vdec_vectors.txt
// columns, all hex: sew widen narrow vm vs2_src vd_src imm5 xs1 vl vstart mask
// then expected eew, expected beat count, flush after this many beats (0 means no flush)
// effective width and vl clamp at each sew
0 0 0 1 0 0 00 00000000 10 00 00000000 0 08 00
0 0 0 1 0 0 00 00000000 20 03 00000000 0 07 00
1 1 0 1 0 0 00 00000000 0c 00 00000000 2 04 00
2 1 0 1 0 0 00 00000000 09 01 00000000 2 02 00
0 1 0 1 0 0 00 00000000 05 00 00000000 1 03 00
2 0 1 1 0 0 00 00000000 04 00 00000000 1 02 00
1 0 1 1 0 0 00 00000000 06 02 00000000 0 02 00
0 0 1 1 0 0 00 00000000 03 00 00000000 0 02 00
// vstart at or past the limit
1 0 0 1 0 0 00 00000000 08 08 00000000 1 01 00
2 0 0 1 0 0 00 00000000 03 06 00000000 2 01 00
// offset sources
0 0 0 1 1 1 0b 00000005 06 00 00000000 0 03 00
0 0 0 1 2 2 0b 123456f3 08 00 00000000 0 04 00
1 0 0 1 3 3 1f 00000005 08 01 00000000 1 04 00
2 0 0 1 4 4 0b 00000005 04 00 00000000 2 02 00
0 0 0 1 5 0 0b 00000005 06 00 00000000 0 03 00
0 0 0 1 6 1 0b 0000002a 04 00 00000000 0 02 00
1 0 0 1 7 4 13 00000005 05 00 00000000 1 03 00
// masked and unmasked write enables
0 0 0 0 0 0 00 00000000 10 00 5a3cc3a5 0 08 00
0 0 0 0 0 0 00 00000000 0e 01 0000f00d 0 07 00
1 0 0 0 0 0 00 00000000 07 00 000000b6 1 04 00
2 0 0 1 0 0 00 00000000 03 00 00000000 2 02 00
// flush mid-command, then normal commands again
0 0 0 1 0 0 00 00000000 10 00 00000000 0 08 03
1 0 0 0 2 3 04 00000010 08 00 00000055 1 04 00
0 0 0 1 0 0 00 00000000 20 02 00000000 0 07 01
2 1 0 1 0 0 00 00000000 20 00 00000000 2 02 00
1 1 0 0 5 4 00 00000000 08 03 ffffffff 2 03 00
